//--- design/video_win_pkg.sv
package video_win_pkg;

	// number of windows, also the width of each bitmap and of the need mask
	localparam int WIN_NUM = 8;

	// stream payload
	localparam int PIXEL_WIDTH = 8;

	// raster geometry widths
	localparam int IMG_WBITS = 12; // column, width, left, window width
	localparam int IMG_HBITS = 12; // row, height, top, window height

	// tuser is {need mask, sof}
	localparam int USER_WIDTH = WIN_NUM + 1;

endpackage

//--- design/frame_scanner.sv
`timescale 1ns/100ps

module frame_scanner (
	input  logic                                clk,
	input  logic                                resetn,
	input  logic                                fsync,
	input  logic [video_win_pkg::IMG_WBITS-1:0] width,
	input  logic [video_win_pkg::IMG_HBITS-1:0] height,
	input  logic                                advance,
	output logic                                frame_start,
	output logic                                pix_valid,
	output logic [video_win_pkg::IMG_WBITS-1:0] pix_col,
	output logic [video_win_pkg::IMG_HBITS-1:0] pix_row,
	output logic                                pix_sof,
	output logic                                pix_eol
);
	import video_win_pkg::*;

	logic [IMG_WBITS-1:0] frm_width;
	logic [IMG_HBITS-1:0] frm_height;
	logic                 last_col;
	logic                 last_row;
	logic                 step;

	// a frame only starts from idle, and only when it has pixels
	assign frame_start = fsync && !pix_valid && (width != '0) && (height != '0);

	assign last_col = (pix_col == frm_width - IMG_WBITS'(1));
	assign last_row = (pix_row == frm_height - IMG_HBITS'(1));
	assign step     = pix_valid && advance; // stage a pixel moves on

	// sizes held for the whole frame
	always_ff @(posedge clk) begin
		if (frame_start) begin
			frm_width  <= width;
			frm_height <= height;
		end
	end

	// pix_valid doubles as the idle/active state
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_valid <= 1'b0;
		end else if (frame_start) begin
			pix_valid <= 1'b1;
		end else if (step && last_col && last_row) begin
			pix_valid <= 1'b0; // back to idle after the last pixel
		end
	end

	// raster counter
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_col <= '0;
			pix_row <= '0;
		end else if (frame_start) begin
			pix_col <= '0;
			pix_row <= '0;
		end else if (step) begin
			if (last_col) begin
				pix_col <= '0;
				if (last_row) begin
					pix_row <= '0;
				end else begin
					pix_row <= pix_row + IMG_HBITS'(1);
				end
			end else begin
				pix_col <= pix_col + IMG_WBITS'(1);
			end
		end
	end

	assign pix_sof = pix_valid && (pix_col == '0) && (pix_row == '0);
	assign pix_eol = pix_valid && last_col;

	// counter never runs past the latched frame
	a_col_in_frame: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid |-> (pix_col < frm_width) && (pix_row < frm_height));

endmodule

//--- design/win_hit.sv
`timescale 1ns/100ps

module win_hit (
	input  logic                                clk,
	input  logic                                resetn,
	input  logic                                frame_start,
	input  logic                                advance,
	input  logic [video_win_pkg::IMG_WBITS-1:0] pix_col,
	input  logic [video_win_pkg::IMG_HBITS-1:0] pix_row,
	input  logic [video_win_pkg::IMG_WBITS-1:0] left,
	input  logic [video_win_pkg::IMG_HBITS-1:0] top,
	input  logic [video_win_pkg::IMG_WBITS-1:0] win_width,
	input  logic [video_win_pkg::IMG_HBITS-1:0] win_height,
	output logic                                hit
);
	import video_win_pkg::*;

	logic [IMG_WBITS-1:0] rect_left;
	logic [IMG_HBITS-1:0] rect_top;
	logic [IMG_WBITS-1:0] rect_width;
	logic [IMG_HBITS-1:0] rect_height;
	logic [IMG_WBITS:0]   right_edge;  // one bit wider so the sum cannot wrap
	logic [IMG_HBITS:0]   bottom_edge;
	logic                 in_cols;
	logic                 in_rows;

	// rectangle only changes between frames
	always_ff @(posedge clk) begin
		if (frame_start) begin
			rect_left   <= left;
			rect_top    <= top;
			rect_width  <= win_width;
			rect_height <= win_height;
		end
	end

	assign right_edge  = {1'b0, rect_left} + {1'b0, rect_width};
	assign bottom_edge = {1'b0, rect_top} + {1'b0, rect_height};

	// half-open ranges, so a zero size gives an empty window
	assign in_cols = (pix_col >= rect_left) && ({1'b0, pix_col} < right_edge);
	assign in_rows = (pix_row >= rect_top) && ({1'b0, pix_row} < bottom_edge);

	// stage b hit
	always_ff @(posedge clk) begin
		if (!resetn) begin
			hit <= 1'b0;
		end else if (advance) begin
			hit <= in_cols && in_rows;
		end
	end

	a_empty_never_hits: assert property (@(posedge clk) disable iff (!resetn)
		(advance && (rect_width == '0)) |=> !hit);

endmodule

//--- design/stream_out.sv
`timescale 1ns/100ps

module stream_out (
	input  logic                                  clk,
	input  logic                                  resetn,
	input  logic                                  pix_valid,
	input  logic [video_win_pkg::IMG_WBITS-1:0]   pix_col,
	input  logic [video_win_pkg::IMG_HBITS-1:0]   pix_row,
	input  logic                                  pix_sof,
	input  logic                                  pix_eol,
	input  logic [video_win_pkg::WIN_NUM-1:0]     hit,
	input  logic [video_win_pkg::WIN_NUM-1:0]     win_dst_bmp [video_win_pkg::WIN_NUM],
	output logic                                  advance,
	output logic                                  m_axis_tvalid,
	output logic [video_win_pkg::PIXEL_WIDTH-1:0] m_axis_tdata,
	output logic [video_win_pkg::USER_WIDTH-1:0]  m_axis_tuser,
	output logic                                  m_axis_tlast,
	input  logic                                  m_axis_tready
);
	import video_win_pkg::*;

	logic                   b_valid;
	logic                   b_sof;
	logic                   b_eol;
	logic [PIXEL_WIDTH-1:0] b_data;
	logic [WIN_NUM-1:0]     need_mask;

	// whole pipeline steps when the output slot frees up
	assign advance = !m_axis_tvalid || m_axis_tready;

	// stage b, lined up with the window hit registers
	always_ff @(posedge clk) begin
		if (!resetn) begin
			b_valid <= 1'b0;
		end else if (advance) begin
			b_valid <= pix_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			b_sof  <= pix_sof;
			b_eol  <= pix_eol;
			b_data <= pix_col[PIXEL_WIDTH-1:0] + pix_row[PIXEL_WIDTH-1:0]; // test pattern
		end
	end

	// consumers needing this pixel
	always_comb begin
		need_mask = '0;
		for (int i = 0; i < WIN_NUM; i++) begin
			if (hit[i]) begin
				need_mask = need_mask | win_dst_bmp[i];
			end
		end
	end

	// stage c, output register
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_axis_tvalid <= 1'b0;
		end else if (advance) begin
			m_axis_tvalid <= b_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			m_axis_tdata <= b_data;
			m_axis_tuser <= {need_mask, b_sof};
			m_axis_tlast <= b_eol;
		end
	end

	// beat held until taken
	a_stall_stable: assert property (@(posedge clk) disable iff (!resetn)
		(m_axis_tvalid && !m_axis_tready) |=>
			m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser)
			&& $stable(m_axis_tlast));

endmodule

//--- design/video_win_gen.sv
`timescale 1ns/100ps

module video_win_gen (
	input  logic                                  clk,
	input  logic                                  resetn,
	input  logic                                  fsync,
	input  logic [video_win_pkg::IMG_WBITS-1:0]   width,
	input  logic [video_win_pkg::IMG_HBITS-1:0]   height,
	input  logic [video_win_pkg::IMG_WBITS-1:0]   win_left   [video_win_pkg::WIN_NUM],
	input  logic [video_win_pkg::IMG_HBITS-1:0]   win_top    [video_win_pkg::WIN_NUM],
	input  logic [video_win_pkg::IMG_WBITS-1:0]   win_width  [video_win_pkg::WIN_NUM],
	input  logic [video_win_pkg::IMG_HBITS-1:0]   win_height [video_win_pkg::WIN_NUM],
	input  logic [video_win_pkg::WIN_NUM-1:0]     win_dst_bmp [video_win_pkg::WIN_NUM],
	output logic                                  m_axis_tvalid,
	output logic [video_win_pkg::PIXEL_WIDTH-1:0] m_axis_tdata,
	output logic [video_win_pkg::USER_WIDTH-1:0]  m_axis_tuser,
	output logic                                  m_axis_tlast,
	input  logic                                  m_axis_tready
);
	import video_win_pkg::*;

	logic                 frame_start;
	logic                 advance;
	logic                 pix_valid;
	logic [IMG_WBITS-1:0] pix_col;
	logic [IMG_HBITS-1:0] pix_row;
	logic                 pix_sof;
	logic                 pix_eol;
	logic [WIN_NUM-1:0]   hit; // one bit per window

	frame_scanner u_scanner (
		.clk         (clk),
		.resetn      (resetn),
		.fsync       (fsync),
		.width       (width),
		.height      (height),
		.advance     (advance),
		.frame_start (frame_start),
		.pix_valid   (pix_valid),
		.pix_col     (pix_col),
		.pix_row     (pix_row),
		.pix_sof     (pix_sof),
		.pix_eol     (pix_eol)
	);

	generate
		for (genvar i = 0; i < WIN_NUM; i++) begin : g_win
			win_hit u_win_hit (
				.clk         (clk),
				.resetn      (resetn),
				.frame_start (frame_start),
				.advance     (advance),
				.pix_col     (pix_col),
				.pix_row     (pix_row),
				.left        (win_left[i]),
				.top         (win_top[i]),
				.win_width   (win_width[i]),
				.win_height  (win_height[i]),
				.hit         (hit[i])
			);
		end
	endgenerate

	stream_out u_stream_out (
		.clk           (clk),
		.resetn        (resetn),
		.pix_valid     (pix_valid),
		.pix_col       (pix_col),
		.pix_row       (pix_row),
		.pix_sof       (pix_sof),
		.pix_eol       (pix_eol),
		.hit           (hit),
		.win_dst_bmp   (win_dst_bmp),
		.advance       (advance),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tready (m_axis_tready)
	);

endmodule

//--- dv/tb_video_win_gen.sv
`timescale 1ns/100ps

module tb_video_win_gen;
	import video_win_pkg::*;

	// about 1750 frame pixels times four for back-pressure plus margin
	localparam int CYCLE_LIMIT = 20000;
	localparam logic [31:0] RAND_SEED = 32'he065d867;

	logic                   clk;
	logic                   resetn;
	logic                   fsync;
	logic [IMG_WBITS-1:0]   width;
	logic [IMG_HBITS-1:0]   height;
	logic [IMG_WBITS-1:0]   win_left   [WIN_NUM];
	logic [IMG_HBITS-1:0]   win_top    [WIN_NUM];
	logic [IMG_WBITS-1:0]   win_width  [WIN_NUM];
	logic [IMG_HBITS-1:0]   win_height [WIN_NUM];
	logic [WIN_NUM-1:0]     win_dst_bmp [WIN_NUM];
	logic                   m_axis_tvalid;
	logic [PIXEL_WIDTH-1:0] m_axis_tdata;
	logic [USER_WIDTH-1:0]  m_axis_tuser;
	logic                   m_axis_tlast;
	logic                   m_axis_tready;

	// rectangles as latched by the DUT at frame start
	int exp_left   [WIN_NUM];
	int exp_top    [WIN_NUM];
	int exp_width  [WIN_NUM];
	int exp_height [WIN_NUM];

	// rectangles loaded halfway through a frame
	int nxt_left   [WIN_NUM];
	int nxt_top    [WIN_NUM];
	int nxt_width  [WIN_NUM];
	int nxt_height [WIN_NUM];

	int          check_count;
	int          error_count;
	int          cycle_count;
	logic [31:0] seed_draw;

	video_win_gen UUT (
		.clk           (clk),
		.resetn        (resetn),
		.fsync         (fsync),
		.width         (width),
		.height        (height),
		.win_left      (win_left),
		.win_top       (win_top),
		.win_width     (win_width),
		.win_height    (win_height),
		.win_dst_bmp   (win_dst_bmp),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tready (m_axis_tready)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string test, input string what,
		input int expected, input int actual);
		check_count++;
		if (expected != actual) begin
			error_count++;
			$display("ERROR %s: %s expected 0x%0h, actual 0x%0h",
				test, what, expected, actual);
		end
	endtask

	task automatic set_window(input int idx, input int l, input int t,
		input int w, input int h, input int bmp);
		win_left[idx]    = IMG_WBITS'(l);
		win_top[idx]     = IMG_HBITS'(t);
		win_width[idx]   = IMG_WBITS'(w);
		win_height[idx]  = IMG_HBITS'(h);
		win_dst_bmp[idx] = WIN_NUM'(bmp);
	endtask

	task automatic clear_windows();
		for (int i = 0; i < WIN_NUM; i++) begin
			set_window(i, 0, 0, 0, 0, 0);
			nxt_left[i]   = 0;
			nxt_top[i]    = 0;
			nxt_width[i]  = 0;
			nxt_height[i] = 0;
		end
	endtask

	// bitmaps are not latched and stay as they are
	task automatic load_next_windows();
		for (int i = 0; i < WIN_NUM; i++) begin
			set_window(i, nxt_left[i], nxt_top[i], nxt_width[i], nxt_height[i],
				int'(win_dst_bmp[i]));
		end
	endtask

	task automatic snapshot_windows();
		for (int i = 0; i < WIN_NUM; i++) begin
			exp_left[i]   = int'(win_left[i]);
			exp_top[i]    = int'(win_top[i]);
			exp_width[i]  = int'(win_width[i]);
			exp_height[i] = int'(win_height[i]);
		end
	endtask

	// OR of the bitmaps of every window holding the pixel
	function automatic int expected_mask(input int col, input int row);
		int mask;
		mask = 0;
		for (int i = 0; i < WIN_NUM; i++) begin
			if (col >= exp_left[i] && col < exp_left[i] + exp_width[i] &&
				row >= exp_top[i] && row < exp_top[i] + exp_height[i]) begin
				mask = mask | int'(win_dst_bmp[i]);
			end
		end
		return mask;
	endfunction

	task automatic count_stray_beats(input int cycles, output int stray);
		stray = 0;
		m_axis_tready = 1'b1;
		repeat (cycles) begin
			if (m_axis_tvalid) begin
				stray++;
			end
			@(negedge clk);
		end
	endtask

	// runs one frame and compares every accepted beat with the model
	task automatic run_frame(input string name, input int w, input int h,
		input bit rand_ready, input int fsync_at, input bit change_mid);
		int beats;
		int col;
		int row;
		int exp_user;
		int stray;
		bit pulsed;
		bit changed;
		beats   = 0;
		pulsed  = 1'b0;
		changed = 1'b0;
		@(negedge clk);
		width  = IMG_WBITS'(w);
		height = IMG_HBITS'(h);
		fsync  = 1'b1;
		snapshot_windows();
		@(negedge clk);
		while (beats < w * h) begin
			fsync = 1'b0;
			if (!pulsed && fsync_at >= 0 && beats >= fsync_at) begin
				fsync  = 1'b1; // lands mid-frame
				pulsed = 1'b1;
			end
			if (change_mid && !changed && beats >= (w * h) / 2) begin
				load_next_windows();
				changed = 1'b1;
			end
			if (rand_ready) begin
				m_axis_tready = ($urandom % 3) != 0;
			end else begin
				m_axis_tready = 1'b1;
			end
			if (m_axis_tvalid && m_axis_tready) begin // beat taken on next rising edge
				col      = beats % w;
				row      = beats / w;
				exp_user = (expected_mask(col, row) << 1) | ((col == 0 && row == 0) ? 1 : 0);
				check_value(name, $sformatf("tdata at (%0d,%0d)", col, row),
					(col + row) & 8'hff, int'(m_axis_tdata));
				check_value(name, $sformatf("tuser at (%0d,%0d)", col, row),
					exp_user, int'(m_axis_tuser));
				check_value(name, $sformatf("tlast at (%0d,%0d)", col, row),
					(col == w - 1) ? 1 : 0, int'(m_axis_tlast));
				beats++;
			end
			@(negedge clk);
		end
		fsync = 1'b0;
		count_stray_beats(12, stray);
		check_value(name, "beats after the last one", 0, stray);
	endtask

	task automatic test_idle_and_empty();
		int stray;
		count_stray_beats(20, stray);
		check_value("idle_after_reset", "beats without fsync", 0, stray);
		width  = IMG_WBITS'(0);
		height = IMG_HBITS'(5);
		fsync  = 1'b1;
		@(negedge clk);
		fsync = 1'b0;
		count_stray_beats(20, stray);
		check_value("zero_width", "beats of an empty frame", 0, stray);
	endtask

	task automatic test_plain_frame();
		clear_windows();
		run_frame("plain_frame", 20, 15, 1'b0, -1, 1'b0);
	endtask

	task automatic test_single_window();
		clear_windows();
		set_window(0, 3, 10, 5, 3, 8'b0000_0010);
		run_frame("single_window", 16, 14, 1'b0, -1, 1'b0);
	endtask

	task automatic test_overlap_and_update();
		clear_windows();
		set_window(0, 2, 1, 6, 5, 8'h01);
		set_window(1, 5, 3, 6, 4, 8'h04);
		set_window(7, 0, 0, 16, 1, 8'h80); // top row band
		nxt_left[0] = 8;
		nxt_top[0]  = 6;
		nxt_width[0]  = 3;
		nxt_height[0] = 3;
		nxt_left[1] = 9;
		nxt_top[1]  = 7;
		nxt_width[1]  = 4;
		nxt_height[1] = 2;
		nxt_width[7]  = 16;
		nxt_height[7] = 1;
		run_frame("overlap_frame", 16, 10, 1'b0, -1, 1'b1);
		run_frame("updated_windows", 16, 10, 1'b0, -1, 1'b0);
	endtask

	task automatic test_backpressure();
		clear_windows();
		set_window(0, 0, 0, 4, 20, 8'h11);
		set_window(2, 25, 5, 10, 6, 8'h22); // runs past the right edge
		set_window(5, 10, 8, 12, 4, 8'h41);
		set_window(6, 12, 9, 0, 4, 8'hff); // zero width
		run_frame("random_ready", 30, 20, 1'b1, -1, 1'b0);
	endtask

	task automatic test_fsync_mid_frame();
		clear_windows();
		set_window(3, 5, 5, 6, 6, 8'h08);
		run_frame("fsync_mid_frame", 20, 15, 1'b0, 150, 1'b0);
	endtask

	initial begin
		seed_draw     = $urandom(RAND_SEED);
		clk           = 1'b0;
		resetn        = 1'b0;
		fsync         = 1'b0;
		width         = '0;
		height        = '0;
		m_axis_tready = 1'b0;
		check_count   = 0;
		error_count   = 0;
		clear_windows();
		repeat (10) @(negedge clk);
		resetn = 1'b1;

		test_idle_and_empty();
		test_plain_frame();
		test_single_window();
		test_overlap_and_update();
		test_backpressure();
		test_fsync_mid_frame();

		$display("summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- project.f
design/video_win_pkg.sv
design/frame_scanner.sv
design/win_hit.sv
design/stream_out.sv
design/video_win_gen.sv
dv/tb_video_win_gen.sv

//--- run_sim.sh
#!/bin/sh
# builds the video window generator testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

TOP=tb_video_win_gen
LOG=sim.log
BUILD_LOG=build.log

rm -f "$LOG" "$BUILD_LOG"

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" -f project.f -Mdir obj_dir > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/V"$TOP" > "$LOG" 2>&1 || echo "simulator returned an error status"
cat "$LOG"

grep -q "All checks passed" "$LOG" \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see $LOG"; exit 1; }
